// File: vlog.f
common/cpu_pkg.sv
alu/vedic_mult.sv
alu/alu.sv
register_file/register_file.sv
hdl/program_mem.sv
hdl/sequencer.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpu_tb -f vlog.f -o cpu_tb_sim || exit 1
out="$(./obj_dir/cpu_tb_sim)"
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  typedef logic [cpu_pkg::NUM_REGS-1:0][cpu_pkg::DATA_W-1:0]   regs_t;
  typedef logic [cpu_pkg::PROG_DEPTH-1:0][cpu_pkg::DATA_W-1:0] prog_t;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic                 clk;
  logic                 reset;
  logic                 prog_valid;
  cpu_pkg::prog_write_t prog_data;
  logic                 load_valid;
  cpu_pkg::port_load_t  load_data;
  logic                 run_valid;
  logic                 prog_ready;
  logic                 load_ready;
  logic                 run_ready;
  logic                 busy;
  cpu_pkg::data_t       port0_out;
  cpu_pkg::data_t       port1_out;

  regs_t          model_regs;  // Expected state of all registers
  cpu_pkg::data_t exp_r0;
  cpu_pkg::data_t exp_r1;
  int             cmp_req = 0;
  int             cmp_done = 0;

  cpu_top i_cpu_top (
    .clk        (clk),
    .reset      (reset),
    .prog_valid (prog_valid),
    .prog_data  (prog_data),
    .load_valid (load_valid),
    .load_data  (load_data),
    .run_valid  (run_valid),
    .prog_ready (prog_ready),
    .load_ready (load_ready),
    .run_ready  (run_ready),
    .busy       (busy),
    .port0_out  (port0_out),
    .port1_out  (port1_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value check failed");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Run aborted");
  endtask

  // Sequential execution of all 32 words after the r0/r1 load
  function automatic regs_t run_model(input prog_t prog, input regs_t start,
                                      input cpu_pkg::port_load_t ld);
    regs_t           r;
    cpu_pkg::instr_t w;
    logic [3:0]      op;
    cpu_pkg::data_t  a;
    cpu_pkg::data_t  b;
    cpu_pkg::data_t  y;
    r    = start;
    r[0] = ld.r0;
    r[1] = ld.r1;
    for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++)
    begin
      w  = prog[i];
      op = w.op;
      a  = r[w.ra];
      b  = r[w.rb];
      case (op)
        4'd0:    y = a + b;
        4'd1:    y = a - b;
        4'd2:    y = 32'(a[15:0]) * 32'(b[15:0]);  // Low halves only
        4'd3:    y = a & b;
        4'd4:    y = a | b;
        4'd5:    y = a ^ b;
        4'd6:    y = (a > b) ? 32'd1 : 32'd0;
        4'd7:    y = (a < b) ? 32'd1 : 32'd0;
        4'd9:    y = a;
        default: y = '0;
      endcase
      r[w.rd] = y;
    end
    return r;
  endfunction

  // Compares the ports with the expected values on request
  always @(negedge clk)
  begin
    if (cmp_done != cmp_req)
    begin
      compare_value("port0_out", exp_r0, port0_out);
      compare_value("port1_out", exp_r1, port1_out);
      cmp_done = cmp_req;
    end
  end

  task automatic expect_ports(input cpu_pkg::data_t r0, input cpu_pkg::data_t r1);
    int n = 0;
    exp_r0  = r0;
    exp_r1  = r1;
    cmp_req = cmp_req + 1;
    while (cmp_done != cmp_req)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("Port comparison never completed");
    end
  endtask

  task automatic wait_ready(input int chan);  // 0 prog, 1 load, 2 run
    int n = 0;
    while (!((chan == 0) ? prog_ready : (chan == 1) ? load_ready : run_ready))
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("A channel never became ready");
    end
  endtask

  task automatic wait_busy(input logic level);
    int n = 0;
    while (busy !== level)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run(level ? "busy never rose after the run request" : "busy never fell");
    end
  endtask

  function automatic cpu_pkg::instr_t make_instr(input logic [3:0] op, input int rd,
                                                 input int ra, input int rb);
    cpu_pkg::instr_t w;
    w.op     = cpu_pkg::alu_op_e'(op);
    w.rd     = 3'(rd);
    w.ra     = 3'(ra);
    w.rb     = 3'(rb);
    w.unused = 19'($urandom);  // Must be ignored
    return w;
  endfunction

  function automatic logic [3:0] undef_op(input int k);
    return (k % 7 == 0) ? 4'd8 : 4'(9 + k % 7);
  endfunction

  function automatic logic [3:0] rand_op();
    int k = $urandom % 9;
    return (k == 8) ? 4'd9 : 4'(k);
  endfunction

  function automatic cpu_pkg::port_load_t rand_load();
    cpu_pkg::port_load_t ld;
    ld.r0 = $urandom;
    ld.r1 = $urandom;
    return ld;
  endfunction

  task automatic write_program(input prog_t p);
    for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++)
    begin
      @(negedge clk);
      prog_valid     = 1'b1;
      prog_data.addr = 5'(i);
      prog_data.word = p[i];
      wait_ready(0);
    end
    @(negedge clk);
    prog_valid = 1'b0;
  endtask

  task automatic load_regs(input cpu_pkg::port_load_t ld);
    @(negedge clk);
    load_valid = 1'b1;
    load_data  = ld;
    wait_ready(1);
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic start_run();
    @(negedge clk);
    run_valid = 1'b1;
    wait_ready(2);
    @(negedge clk);
    run_valid = 1'b0;
    wait_busy(1'b1);
  endtask

  task automatic run_and_check(input prog_t p, input cpu_pkg::port_load_t ld);
    write_program(p);
    load_regs(ld);
    start_run();
    wait_busy(1'b0);
    model_regs = run_model(p, model_regs, ld);
    expect_ports(model_regs[0], model_regs[1]);
  endtask

  // Result moved to r0, filler only touches r7
  task automatic op_trial(input logic [3:0] op, input cpu_pkg::data_t a, input cpu_pkg::data_t b);
    prog_t               p;
    cpu_pkg::port_load_t ld;
    p[0] = make_instr(op, 2, 0, 1);
    p[1] = make_instr(4'd9, 0, 2, 0);
    for (int i = 2; i < cpu_pkg::PROG_DEPTH; i++)
      p[i] = make_instr(4'd9, 7, 7, 0);
    ld.r0 = a;
    ld.r1 = b;
    run_and_check(p, ld);
  endtask

  initial
  begin
    prog_t               p;
    cpu_pkg::port_load_t ld;
    cpu_pkg::port_load_t held;
    cpu_pkg::data_t      new_word;
    cpu_pkg::data_t      x;
    cpu_pkg::data_t      y;
    logic [3:0]          op;
    int                  n;
    void'($urandom(58628));
    reset      = 1'b1;
    prog_valid = 1'b0;
    prog_data  = '0;
    load_valid = 1'b0;
    load_data  = '0;
    run_valid  = 1'b0;
    model_regs = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    compare_value("busy", 32'd0, 32'(busy));
    compare_value("prog_ready", 32'd1, 32'(prog_ready));
    compare_value("load_ready", 32'd1, 32'(load_ready));
    compare_value("run_ready", 32'd1, 32'(run_ready));
    compare_value("port0_out", 32'd0, port0_out);
    compare_value("port1_out", 32'd0, port1_out);

    // Undefined opcodes and PASS copies
    for (int i = 0; i < 24; i++)
      p[i] = make_instr((i % 2 == 1) ? undef_op(i) : 4'd9, 2 + i % 6, i % 8, 0);
    for (int i = 24; i < cpu_pkg::PROG_DEPTH; i++)
      p[i] = make_instr((i == 31) ? undef_op(i) : 4'd9, i % 2, 2 + i % 6, 0);
    run_and_check(p, rand_load());

    for (int k = 0; k < 9; k++)
    begin
      op = (k == 8) ? 4'd9 : 4'(k);
      op_trial(op, $urandom, $urandom);
      if (op == 4'd6 || op == 4'd7)
      begin
        x = $urandom;
        y = x ^ ($urandom | 32'd1);  // Never equal to x
        op_trial(op, x, x);
        op_trial(op, (x > y) ? x : y, (x > y) ? y : x);
        op_trial(op, (x > y) ? y : x, (x > y) ? x : y);
      end
    end

    // Each word reads the previous destination
    for (int t = 0; t < 2; t++)
    begin
      for (int i = 0; i < 30; i++)
        p[i] = make_instr(rand_op(), 2 + i % 6, (i == 0) ? 0 : 2 + (i - 1) % 6, $urandom % 8);
      p[30] = make_instr(4'd9, 0, 7, 0);
      p[31] = make_instr(4'd0, 1, 0, 1);
      run_and_check(p, rand_load());
    end

    // Requests held on all channels during a run
    for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++)
      p[i] = $urandom;
    ld = rand_load();
    write_program(p);
    load_regs(ld);
    start_run();
    held           = rand_load();
    new_word       = $urandom;
    prog_valid     = 1'b1;
    prog_data.addr = 5'd5;
    prog_data.word = new_word;
    load_valid     = 1'b1;
    load_data      = held;
    run_valid      = 1'b1;
    n = 0;
    while (busy)
    begin
      compare_value("prog_ready", 32'd0, 32'(prog_ready));
      compare_value("load_ready", 32'd0, 32'(load_ready));
      compare_value("run_ready", 32'd0, 32'(run_ready));
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_run("busy never fell while requests were held");
    end
    model_regs = run_model(p, model_regs, ld);
    compare_value("port0_out", model_regs[0], port0_out);
    compare_value("port1_out", model_regs[1], port1_out);
    @(negedge clk);  // Held requests taken on this edge
    prog_valid = 1'b0;
    load_valid = 1'b0;
    run_valid  = 1'b0;
    compare_value("busy", 32'd1, 32'(busy));
    compare_value("port0_out", held.r0, port0_out);
    compare_value("port1_out", held.r1, port1_out);
    p[5] = new_word;
    wait_busy(1'b0);
    model_regs = run_model(p, model_regs, held);
    expect_ports(model_regs[0], model_regs[1]);

    for (int t = 0; t < 10; t++)
    begin
      for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++)
        p[i] = $urandom;
      run_and_check(p, rand_load());
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  prog_valid,
  input  wire cpu_pkg::prog_write_t prog_data,
  input  wire                  load_valid,
  input  wire cpu_pkg::port_load_t  load_data,
  input  wire                  run_valid,
  output logic                 prog_ready,
  output logic                 load_ready,
  output logic                 run_ready,
  output logic                 busy,
  output cpu_pkg::data_t       port0_out,
  output cpu_pkg::data_t       port1_out
);

  logic                prog_we;
  logic                load_en;
  cpu_pkg::prog_addr_t fetch_addr;
  cpu_pkg::instr_t     fetch_word;
  cpu_pkg::exec_t      exec;
  cpu_pkg::data_t      operand_a;
  cpu_pkg::data_t      operand_b;
  cpu_pkg::data_t      result;

  // Control: handshakes, run state and pipeline
  sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .prog_valid (prog_valid),
    .load_valid (load_valid),
    .run_valid  (run_valid),
    .fetch_word (fetch_word),
    .prog_ready (prog_ready),
    .load_ready (load_ready),
    .run_ready  (run_ready),
    .prog_we    (prog_we),
    .load_en    (load_en),
    .busy       (busy),
    .fetch_addr (fetch_addr),
    .exec       (exec)
  );

  program_mem u_program_mem (
    .clk        (clk),
    .prog_we    (prog_we),
    .prog_data  (prog_data),
    .fetch_addr (fetch_addr),
    .fetch_word (fetch_word)
  );

  register_file u_register_file (
    .clk       (clk),
    .reset     (reset),
    .exec      (exec),
    .result    (result),
    .load_en   (load_en),
    .load_data (load_data),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .port0_out (port0_out),
    .port1_out (port1_out)
  );

  alu u_alu (
    .exec      (exec),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: hdl/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  prog_valid,
  input  wire                  load_valid,
  input  wire                  run_valid,
  input  wire cpu_pkg::instr_t fetch_word,
  output logic                 prog_ready,
  output logic                 load_ready,
  output logic                 run_ready,
  output logic                 prog_we,
  output logic                 load_en,
  output logic                 busy,
  output cpu_pkg::prog_addr_t  fetch_addr,
  output cpu_pkg::exec_t       exec
);

  localparam cpu_pkg::prog_addr_t LAST_ADDR = cpu_pkg::prog_addr_t'(cpu_pkg::PROG_DEPTH - 1);

  logic run_fire;
  logic fetch_v;  // fetch_addr carries a real address this cycle
  logic word_v;   // fetch_word is a real program word this cycle

  // All channels open only while idle
  assign prog_ready = !busy;
  assign load_ready = !busy;
  assign run_ready  = !busy;

  assign prog_we  = prog_valid && prog_ready;
  assign load_en  = load_valid && load_ready;
  assign run_fire = run_valid && run_ready;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy       <= 1'b0;
      fetch_v    <= 1'b0;
      word_v     <= 1'b0;
      fetch_addr <= '0;
      exec       <= '0;
    end
    else
    begin
      // Memory read latency is one cycle
      word_v <= fetch_v;

      // Instruction register
      exec.op    <= fetch_word.op;
      exec.rd    <= fetch_word.rd;
      exec.ra    <= fetch_word.ra;
      exec.rb    <= fetch_word.rb;
      exec.wr_en <= word_v;  // Fill and drain write nothing

      if (run_fire)
      begin
        busy       <= 1'b1;
        fetch_v    <= 1'b1;
        fetch_addr <= '0;
      end
      else if (fetch_v)
      begin
        fetch_addr <= fetch_addr + cpu_pkg::prog_addr_t'(1);
        if (fetch_addr == LAST_ADDR)
          fetch_v <= 1'b0;
      end

      // Last word in execute with nothing behind it
      if (busy && exec.wr_en && !word_v)
        busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/program_mem.sv
`timescale 1ns/1ps
`default_nettype none

module program_mem (
  input  wire                       clk,
  input  wire                       prog_we,
  input  wire cpu_pkg::prog_write_t prog_data,
  input  wire cpu_pkg::prog_addr_t  fetch_addr,
  output cpu_pkg::instr_t           fetch_word
);

  cpu_pkg::instr_t     mem [cpu_pkg::PROG_DEPTH];
  cpu_pkg::prog_addr_t addr_q;

  always_ff @(posedge clk)
  begin
    if (prog_we)
      mem[prog_data.addr] <= prog_data.word;
    addr_q <= fetch_addr;  // Registered read address
  end

  // Word shows up one cycle after its address
  assign fetch_word = mem[addr_q];

endmodule

`default_nettype wire

// File: register_file/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                      clk,
  input  wire                      reset,
  input  wire cpu_pkg::exec_t      exec,
  input  wire cpu_pkg::data_t      result,
  input  wire                      load_en,
  input  wire cpu_pkg::port_load_t load_data,
  output cpu_pkg::data_t           operand_a,
  output cpu_pkg::data_t           operand_b,
  output cpu_pkg::data_t           port0_out,
  output cpu_pkg::data_t           port1_out
);

  cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      // Host load of r0/r1, only while idle
      if (load_en)
      begin
        regs[0] <= load_data.r0;
        regs[1] <= load_data.r1;
      end
      if (exec.wr_en)
        regs[exec.rd] <= result;  // Write-back at end of execute
    end
  end

  // Combinational reads see the previous instruction's write
  assign operand_a = regs[exec.ra];
  assign operand_b = regs[exec.rb];

  assign port0_out = regs[0];
  assign port1_out = regs[1];

endmodule

`default_nettype wire

// File: alu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire cpu_pkg::exec_t exec,
  input  wire cpu_pkg::data_t operand_a,
  input  wire cpu_pkg::data_t operand_b,
  output cpu_pkg::data_t      result
);

  logic [2*cpu_pkg::MUL_W-1:0] mul_product;

  // Product of the low halves only
  vedic_mult #(
    .WIDTH (cpu_pkg::MUL_W)
  ) u_vedic_mult (
    .a       (operand_a[cpu_pkg::MUL_W-1:0]),
    .b       (operand_b[cpu_pkg::MUL_W-1:0]),
    .product (mul_product)
  );

  always_comb
  begin
    case (exec.op)
      cpu_pkg::ADD:
        result = operand_a + operand_b;  // Wraps mod 2^32
      cpu_pkg::SUB:
        result = operand_a - operand_b;
      cpu_pkg::MUL:
        result = mul_product;
      cpu_pkg::AND:
        result = operand_a & operand_b;
      cpu_pkg::OR:
        result = operand_a | operand_b;
      cpu_pkg::XOR:
        result = operand_a ^ operand_b;
      // Unsigned compares give 1 or 0
      cpu_pkg::GT:
        result = {{(cpu_pkg::DATA_W-1){1'b0}}, operand_a > operand_b};
      cpu_pkg::LT:
        result = {{(cpu_pkg::DATA_W-1){1'b0}}, operand_a < operand_b};
      cpu_pkg::PASS:
        result = operand_a;
      default:
        result = '0;  // Undefined opcodes
    endcase
  end

endmodule

`default_nettype wire

// File: alu/vedic_mult.sv
`timescale 1ns/1ps
`default_nettype none

// Recursion stops at width 2 or at an odd width
module vedic_mult #(
  parameter int WIDTH = 16
) (
  input  wire  [WIDTH-1:0]   a,
  input  wire  [WIDTH-1:0]   b,
  output logic [2*WIDTH-1:0] product
);

  generate
    if ((WIDTH <= 2) || (WIDTH % 2 != 0))
    begin : g_leaf
      assign product = {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
    end
    else
    begin : g_split
      localparam int HALF = WIDTH / 2;

      // Half-width partial products
      logic [WIDTH-1:0]   pp_ll;
      logic [WIDTH-1:0]   pp_hl;
      logic [WIDTH-1:0]   pp_lh;
      logic [WIDTH-1:0]   pp_hh;
      logic [2*WIDTH-1:0] t_ll;
      logic [2*WIDTH-1:0] t_hl;
      logic [2*WIDTH-1:0] t_lh;
      logic [2*WIDTH-1:0] t_hh;

      vedic_mult #(.WIDTH(HALF)) u_ll (.a(a[HALF-1:0]),     .b(b[HALF-1:0]),     .product(pp_ll));
      vedic_mult #(.WIDTH(HALF)) u_hl (.a(a[WIDTH-1:HALF]), .b(b[HALF-1:0]),     .product(pp_hl));
      vedic_mult #(.WIDTH(HALF)) u_lh (.a(a[HALF-1:0]),     .b(b[WIDTH-1:HALF]), .product(pp_lh));
      vedic_mult #(.WIDTH(HALF)) u_hh (.a(a[WIDTH-1:HALF]), .b(b[WIDTH-1:HALF]), .product(pp_hh));

      // Cross terms shift by HALF and the high term by WIDTH
      assign t_ll = {{WIDTH{1'b0}}, pp_ll};
      assign t_hl = {{HALF{1'b0}}, pp_hl, {HALF{1'b0}}};
      assign t_lh = {{HALF{1'b0}}, pp_lh, {HALF{1'b0}}};
      assign t_hh = {pp_hh, {WIDTH{1'b0}}};

      assign product = t_ll + t_hl + t_lh + t_hh;  // Full width keeps every carry
    end
  endgenerate

endmodule

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int DATA_W     = 32;
  localparam int NUM_REGS   = 8;
  localparam int PROG_DEPTH = 32;
  localparam int MUL_W      = 16;  // Low half of a word

  typedef logic [DATA_W-1:0]              data_t;
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
  typedef logic [$clog2(PROG_DEPTH)-1:0] prog_addr_t;

  // Codes 8 and 10..15 are undefined and write zero
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    MUL  = 4'd2,
    AND  = 4'd3,
    OR   = 4'd4,
    XOR  = 4'd5,
    GT   = 4'd6,
    LT   = 4'd7,
    PASS = 4'd9
  } alu_op_e;

  typedef struct packed {
    alu_op_e                  op;
    reg_idx_t                 rd;
    reg_idx_t                 ra;
    reg_idx_t                 rb;
    logic [DATA_W-14:0]       unused;  // Ignored by the machine
  } instr_t;

  typedef struct packed {
    prog_addr_t addr;
    instr_t     word;
  } prog_write_t;

  typedef struct packed {
    data_t r0;
    data_t r1;
  } port_load_t;

  // Instruction in the execute stage
  typedef struct packed {
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    logic     wr_en;
  } exec_t;

endpackage

`default_nettype wire
